// File: tb/shoot_stimulus.txt
// mode(0 solo, 1 multi) xpos ypos keeper_pos enemy_is_scored credit_delay expected_is_scored
// all fields hex, one record per line
0 12c 190 000 0 00 1
0 1f4 190 000 0 00 0
0 064 0c8 000 0 00 0
0 0d4 096 000 0 00 1
0 32c 258 000 0 00 1
0 258 226 000 0 00 0
// first multi shot keeps its credits long enough to stall the next one
1 2a5 1c3 0c8 1 60 1
1 137 0ab 3f0 0 20 0
1 3ff 2ff 1f4 1 00 1
1 1e0 200 300 0 10 0

// File: src.f
+incdir+tb
logic/shoot_pkg.sv
logic/keeper_window.sv
logic/keeper_overlay.sv
logic/shot_fsm.sv
logic/shot_tx.sv
logic/shoot_control.sv
tb/shoot_control_tb.sv

// File: Bender.yml
package:
  name: shoot_control

sources:
  - logic/shoot_pkg.sv
  - logic/keeper_window.sv
  - logic/keeper_overlay.sv
  - logic/shot_fsm.sv
  - logic/shot_tx.sv
  - logic/shoot_control.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/shoot_control_tb.sv

// File: tb/shoot_checks.svh
`ifndef SHOOT_CHECKS_SVH
`define SHOOT_CHECKS_SVH

task automatic check_rgb(input string name, input rgb_t expected, input rgb_t actual);
    if (actual !== expected) begin
        abort_run($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
    end
endtask

task automatic check_pix(input string name, input pix_t expected, input pix_t actual);
    if (actual !== expected) begin
        abort_run($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
    end
endtask

task automatic check_byte(input string name, input tx_byte_t expected, input tx_byte_t actual);
    if (actual !== expected) begin
        abort_run($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
    end
endtask

task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        abort_run($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
    end
endtask

// 32-bit xorshift with shifts 13, 17 and 5
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] r;
    r = s ^ (s << 13);
    r = r ^ (r >> 17);
    r = r ^ (r << 5);
    return r;
endfunction

`endif

// File: tb/shoot_control_tb.sv
`timescale 1ns/10ps

module shoot_control_tb;
    import shoot_pkg::*;

    localparam int HOLD_CYCLES       = 20;
    localparam int REC_WORDS         = 7;
    localparam int MAX_RECORDS       = 32;
    localparam int CYCLES_PER_RECORD = 2 * HOLD_CYCLES + 200;

    logic       clk;
    logic       rst;
    game_mode_t game_mode;
    logic       active;
    pix_t       xpos;
    pix_t       ypos;
    logic       clicked;
    edge_t      keeper_pos;
    logic       enemy_done;
    logic       enemy_is_scored;
    pix_t       hcount;
    pix_t       vcount;
    rgb_t       rgb_in;
    logic       tx_credit;
    pix_t       hcount_out;
    pix_t       vcount_out;
    rgb_t       rgb_out;
    logic       is_scored;
    logic       round_done;
    logic       end_sh;
    logic       shot_taken;
    logic       tx_valid;
    tx_byte_t   tx_data;

    logic [31:0] stim_mem [MAX_RECORDS * REC_WORDS];
    int          num_records;
    logic [31:0] rng_state;
    logic [31:0] credit_rng;
    tx_byte_t    expected_bytes [$];
    int          in_flight;        // bytes not yet credited back
    int          cycle_cnt;
    int          release_cycle;    // credits held back until this cycle
    int          credit_gap;
    pix_t        left_e;
    pix_t        right_e;

    shoot_control #(
        .HOLD_CYCLES (HOLD_CYCLES)
    ) u_dut (
        .clk             (clk),
        .rst             (rst),
        .game_mode       (game_mode),
        .active          (active),
        .xpos            (xpos),
        .ypos            (ypos),
        .clicked         (clicked),
        .keeper_pos      (keeper_pos),
        .enemy_done      (enemy_done),
        .enemy_is_scored (enemy_is_scored),
        .hcount          (hcount),
        .vcount          (vcount),
        .rgb_in          (rgb_in),
        .tx_credit       (tx_credit),
        .hcount_out      (hcount_out),
        .vcount_out      (vcount_out),
        .rgb_out         (rgb_out),
        .is_scored       (is_scored),
        .round_done      (round_done),
        .end_sh          (end_sh),
        .shot_taken      (shot_taken),
        .tx_valid        (tx_valid),
        .tx_data         (tx_data)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped at first error");
    endtask

`include "shoot_checks.svh"

    // k[0] picks the side, k[1] steps out in x, k[2] steps out in y
    task automatic probe_overlay(input logic painted, input rgb_t color);
        logic [2:0] k;
        rgb_t expected;
        pix_t h_sent;
        pix_t v_sent;
        for (int i = 0; i < 8; i++) begin
            k = 3'(i);
            rng_state = xorshift32(rng_state);
            rgb_in = rng_state[11:0];
            hcount = k[0] ? right_e + k[1] : left_e - k[1];
            vcount = k[0] ? GK_BOTTOM_Y + k[2] : GK_TOP_Y - k[2];
            expected = (painted && k[2:1] == 2'b00) ? color : rgb_in;
            h_sent = hcount;
            v_sent = vcount;
            @(negedge clk);
            check_rgb("rgb_out", expected, rgb_out);
            check_pix("hcount_out", h_sent, hcount_out);
            check_pix("vcount_out", v_sent, vcount_out);
        end
    endtask

    task automatic run_record(input int r);
        logic [31:0] f [REC_WORDS];
        edge_t centre;
        for (int w = 0; w < REC_WORDS; w++) begin
            f[w] = stim_mem[r * REC_WORDS + w];
        end
        game_mode = f[0][0] ? MULTI : SOLO;
        xpos = f[1][10:0];
        ypos = f[2][10:0];
        keeper_pos = f[3][9:0];
        enemy_is_scored = f[4][0];
        release_cycle = cycle_cnt + int'(f[5]);
        if (game_mode == MULTI) begin
            centre = keeper_pos;
            if (keeper_pos < GK_CLAMP_MIN) begin
                centre = GK_CLAMP_MIN;
            end
            else if (keeper_pos > GK_CLAMP_MAX) begin
                centre = GK_CLAMP_MAX;
            end
            left_e = centre - GK_HALF_WIDTH;
            right_e = centre + GK_HALF_WIDTH;
        end
        else begin
            left_e = GK_SOLO_LEFT;
            right_e = GK_SOLO_LEFT + GK_WIDTH;
        end
        @(negedge clk);                    // edges follow keeper_pos
        probe_overlay(1'b0, COLOR_AIM);    // keeper hidden in idle
        active = 1'b1;
        @(negedge clk);
        active = 1'b0;
        @(negedge clk);
        probe_overlay(1'b1, COLOR_AIM);
        clicked = 1'b1;
        if (game_mode == MULTI) begin
            expected_bytes.push_back({xpos[4:0], OP_X_LO});
            expected_bytes.push_back({xpos[9:5], OP_X_HI});
            expected_bytes.push_back({ypos[4:0], OP_Y_LO});
            expected_bytes.push_back({ypos[9:5], OP_Y_HI});
        end
        @(negedge clk);
        clicked = 1'b0;
        check_flag("shot_taken", game_mode == MULTI, shot_taken);
        if (game_mode == MULTI) begin
            enemy_done = 1'b1;
            repeat (RESULT_DEBOUNCE) begin    // one cycle short
                @(negedge clk);
                check_flag("shot_taken", 1'b1, shot_taken);
                check_flag("round_done", 1'b0, round_done);
            end
            enemy_done = 1'b0;
            @(negedge clk);
            check_flag("shot_taken", 1'b1, shot_taken);
            enemy_done = 1'b1;
            repeat (RESULT_DEBOUNCE) begin    // count starts again from zero
                @(negedge clk);
                check_flag("shot_taken", 1'b1, shot_taken);
            end
            @(negedge clk);
            check_flag("shot_taken", 1'b0, shot_taken);
        end
        else begin
            @(negedge clk);
        end
        probe_overlay(1'b1, f[6][0] ? COLOR_GOAL : COLOR_MISS);
        while (!round_done) begin
            @(negedge clk);
        end
        check_flag("is_scored", f[6][0], is_scored);
        do begin
            @(negedge clk);
        end while (!end_sh);
        enemy_done = 1'b0;
        @(negedge clk);    // back in idle
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst) begin
            cycle_cnt++;
        end
    end

    // link receiver checks bytes and hands back credits
    always @(negedge clk) begin
        tx_credit = 1'b0;
        if (!rst) begin
            if (tx_valid) begin
                if (in_flight >= TX_CREDITS) begin
                    abort_run("a byte was sent while the receiver had no free slot");
                end
                if (expected_bytes.size() == 0) begin
                    abort_run("a byte was sent with no shot pending");
                end
                check_byte("tx_data", expected_bytes.pop_front(), tx_data);
            end
            if (in_flight > 0 && cycle_cnt >= release_cycle) begin
                if (credit_gap == 0) begin
                    tx_credit = 1'b1;
                    in_flight--;
                    credit_rng = xorshift32(credit_rng);
                    credit_gap = credit_rng % 3;
                end
                else begin
                    credit_gap--;
                end
            end
            if (tx_valid) begin
                in_flight++;
            end
        end
    end

    initial begin
        wait (num_records > 0);
        repeat (num_records * CYCLES_PER_RECORD + 50) @(posedge clk);
        abort_run("watchdog expired, the DUT stopped responding");
    end

    initial begin
        int n;
        rst = 1'b1;
        game_mode = SOLO;
        active = 1'b0;
        xpos = '0;
        ypos = '0;
        clicked = 1'b0;
        keeper_pos = '0;
        enemy_done = 1'b0;
        enemy_is_scored = 1'b0;
        hcount = '0;
        vcount = '0;
        rgb_in = '0;
        tx_credit = 1'b0;
        rng_state = 32'h7220;
        credit_rng = 32'h7220;
        in_flight = 0;
        cycle_cnt = 0;
        release_cycle = 0;
        credit_gap = 0;
        $readmemh("tb/shoot_stimulus.txt", stim_mem);
        n = 0;
        while (n < MAX_RECORDS && !$isunknown(stim_mem[n * REC_WORDS])) begin
            n++;
        end
        if (n == 0) begin
            abort_run("no records could be read from tb/shoot_stimulus.txt");
        end
        num_records = n;
        repeat (3) @(negedge clk);
        check_rgb("rgb_out", 12'h000, rgb_out);
        rst = 1'b0;
        @(negedge clk);
        check_flag("tx_valid", 1'b0, tx_valid);
        check_flag("round_done", 1'b0, round_done);
        check_flag("end_sh", 1'b0, end_sh);
        check_flag("shot_taken", 1'b0, shot_taken);
        check_flag("is_scored", 1'b0, is_scored);
        for (int r = 0; r < num_records; r++) begin
            run_record(r);
        end
        while (expected_bytes.size() != 0 || in_flight != 0) begin
            @(negedge clk);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: logic/shoot_control.sv
`timescale 1ns/10ps

module shoot_control #(
    parameter int HOLD_CYCLES = shoot_pkg::HOLD_CYCLES_DEFAULT
) (
    input  logic                   clk,
    input  logic                   rst,
    input  shoot_pkg::game_mode_t  game_mode,
    input  logic                   active,
    input  shoot_pkg::pix_t        xpos,
    input  shoot_pkg::pix_t        ypos,
    input  logic                   clicked,
    input  shoot_pkg::edge_t       keeper_pos,
    input  logic                   enemy_done,
    input  logic                   enemy_is_scored,
    input  shoot_pkg::pix_t        hcount,
    input  shoot_pkg::pix_t        vcount,
    input  shoot_pkg::rgb_t        rgb_in,
    input  logic                   tx_credit,
    output shoot_pkg::pix_t        hcount_out,
    output shoot_pkg::pix_t        vcount_out,
    output shoot_pkg::rgb_t        rgb_out,
    output logic                   is_scored,
    output logic                   round_done,
    output logic                   end_sh,
    output logic                   shot_taken,
    output logic                   tx_valid,
    output shoot_pkg::tx_byte_t    tx_data
);
    import shoot_pkg::*;

    edge_t left_edge, right_edge;
    keeper_shade_t shade;
    logic shot_fire;

    keeper_window u_keeper_window (
        .clk        (clk),
        .rst        (rst),
        .game_mode  (game_mode),
        .keeper_pos (keeper_pos),
        .left_edge  (left_edge),
        .right_edge (right_edge)
    );

    keeper_overlay u_keeper_overlay (
        .clk        (clk),
        .rst        (rst),
        .hcount     (hcount),
        .vcount     (vcount),
        .rgb_in     (rgb_in),
        .shade      (shade),
        .left_edge  (left_edge),
        .right_edge (right_edge),
        .hcount_out (hcount_out),
        .vcount_out (vcount_out),
        .rgb_out    (rgb_out)
    );

    shot_fsm #(
        .HOLD_CYCLES (HOLD_CYCLES)
    ) u_shot_fsm (
        .clk             (clk),
        .rst             (rst),
        .game_mode       (game_mode),
        .active          (active),
        .clicked         (clicked),
        .xpos            (xpos),
        .ypos            (ypos),
        .left_edge       (left_edge),
        .right_edge      (right_edge),
        .enemy_done      (enemy_done),
        .enemy_is_scored (enemy_is_scored),
        .shade           (shade),
        .shot_fire       (shot_fire),
        .is_scored       (is_scored),
        .round_done      (round_done),
        .end_sh          (end_sh),
        .shot_taken      (shot_taken)
    );

    // multi mode only, position to the other board
    shot_tx u_shot_tx (
        .clk       (clk),
        .rst       (rst),
        .shot_fire (shot_fire),
        .xpos      (xpos),
        .ypos      (ypos),
        .tx_credit (tx_credit),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data)
    );

endmodule

// File: logic/shot_tx.sv
`timescale 1ns/10ps

module shot_tx (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 shot_fire,
    input  shoot_pkg::pix_t      xpos,
    input  shoot_pkg::pix_t      ypos,
    input  logic                 tx_credit,
    output logic                 tx_valid,
    output shoot_pkg::tx_byte_t  tx_data
);
    import shoot_pkg::*;

    localparam int CREDIT_W = $clog2(TX_CREDITS + 1);

    logic [9:0] shot_x, shot_y;
    logic [1:0] byte_idx;
    logic busy;
    logic [CREDIT_W-1:0] credits;

    // byte goes out whenever one is pending and the receiver has room
    assign tx_valid = busy && (credits != '0);

    always_comb begin
        case (byte_idx)
            2'd0:    tx_data = {shot_x[4:0], OP_X_LO};
            2'd1:    tx_data = {shot_x[9:5], OP_X_HI};
            2'd2:    tx_data = {shot_y[4:0], OP_Y_LO};
            default: tx_data = {shot_y[9:5], OP_Y_HI};
        endcase
    end

    always_ff @(posedge clk) begin
        if (shot_fire) begin
            shot_x <= xpos[9:0];
            shot_y <= ypos[9:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            byte_idx <= '0;
        end
        else if (shot_fire) begin
            busy     <= 1'b1;
            byte_idx <= '0;
        end
        else if (tx_valid) begin
            byte_idx <= byte_idx + 1'b1;
            if (byte_idx == 2'd3) begin
                busy <= 1'b0;    // last byte sent
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CREDIT_W'(TX_CREDITS);
        end
        else if (tx_valid && !tx_credit) begin
            credits <= credits - 1'b1;
        end
        else if (tx_credit && !tx_valid && (credits != CREDIT_W'(TX_CREDITS))) begin
            credits <= credits + 1'b1;
        end
    end

endmodule

// File: logic/shot_fsm.sv
`timescale 1ns/10ps

module shot_fsm #(
    parameter int HOLD_CYCLES = shoot_pkg::HOLD_CYCLES_DEFAULT
) (
    input  logic                      clk,
    input  logic                      rst,
    input  shoot_pkg::game_mode_t     game_mode,
    input  logic                      active,
    input  logic                      clicked,
    input  shoot_pkg::pix_t           xpos,
    input  shoot_pkg::pix_t           ypos,
    input  shoot_pkg::edge_t          left_edge,
    input  shoot_pkg::edge_t          right_edge,
    input  logic                      enemy_done,
    input  logic                      enemy_is_scored,
    output shoot_pkg::keeper_shade_t  shade,
    output logic                      shot_fire,
    output logic                      is_scored,
    output logic                      round_done,
    output logic                      end_sh,
    output logic                      shot_taken
);
    import shoot_pkg::*;

    localparam int CNT_W = $clog2(HOLD_CYCLES + RESULT_DEBOUNCE + 2);

    typedef enum logic [2:0] {
        IDLE,
        ENGAGE,
        AIM,
        JUDGE,
        GOAL,
        MISS,
        TERMINATE
    } state_t;

    state_t state, state_nxt;
    logic [CNT_W-1:0] counter, counter_nxt;    // debounce and hold share it
    pix_t shot_x, shot_y;
    logic in_mouth, in_keeper, solo_goal;
    logic hold_last, term_last;

    assign in_mouth = (shot_x >= POST_INNER_EDGE) &&
                      (shot_x <= SCREEN_WIDTH - POST_INNER_EDGE) &&
                      (shot_y >= CROSSBAR_BOTTOM) && (shot_y <= POST_BOTTOM);
    assign in_keeper = (shot_x >= left_edge) && (shot_x <= right_edge) &&
                       (shot_y >= GK_TOP_Y) && (shot_y <= GK_BOTTOM_Y);
    assign solo_goal = in_mouth && !in_keeper;

    assign hold_last = (counter == CNT_W'(HOLD_CYCLES - 1));
    // solo skips the extra wait
    assign term_last = (game_mode == SOLO) || (counter == CNT_W'(HOLD_CYCLES));

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            counter <= '0;
        end
        else begin
            state   <= state_nxt;
            counter <= counter_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (state == AIM && clicked) begin
            shot_x <= xpos;    // judged next cycle
            shot_y <= ypos;
        end
    end

    always_comb begin
        state_nxt   = state;
        counter_nxt = counter;
        case (state)
            IDLE: begin
                counter_nxt = '0;
                if (active) begin
                    state_nxt = ENGAGE;
                end
            end
            ENGAGE: begin
                state_nxt = AIM;
            end
            AIM: begin
                counter_nxt = '0;
                if (clicked) begin
                    state_nxt = JUDGE;
                end
            end
            JUDGE: begin
                if (game_mode == SOLO) begin
                    if (solo_goal) begin
                        state_nxt = GOAL;
                    end
                    else begin
                        state_nxt = MISS;
                    end
                end
                else if (!enemy_done) begin
                    counter_nxt = '0;    // glitch, start over
                end
                else if (counter == CNT_W'(RESULT_DEBOUNCE)) begin
                    counter_nxt = '0;
                    if (enemy_is_scored) begin
                        state_nxt = GOAL;
                    end
                    else begin
                        state_nxt = MISS;
                    end
                end
                else begin
                    counter_nxt = counter + 1'b1;
                end
            end
            GOAL, MISS: begin
                if (hold_last) begin
                    counter_nxt = '0;
                    state_nxt   = TERMINATE;
                end
                else begin
                    counter_nxt = counter + 1'b1;
                end
            end
            TERMINATE: begin
                if (term_last) begin
                    counter_nxt = '0;
                    state_nxt   = IDLE;
                end
                else begin
                    counter_nxt = counter + 1'b1;
                end
            end
            default: begin
                counter_nxt = '0;
                state_nxt   = IDLE;
            end
        endcase
    end

    always_comb begin
        case (state)
            AIM, JUDGE: shade = SHADE_AIM;
            GOAL:       shade = SHADE_GOAL;
            MISS:       shade = SHADE_MISS;
            default:    shade = SHADE_NONE;
        endcase
    end

    assign shot_fire  = (state == AIM) && clicked && (game_mode == MULTI);
    assign shot_taken = (state == JUDGE) && (game_mode == MULTI);
    assign round_done = ((state == GOAL) || (state == MISS)) && hold_last;
    assign is_scored  = (state == GOAL) && hold_last;    // only with round_done
    assign end_sh     = (state == TERMINATE) && term_last;

endmodule

// File: logic/keeper_overlay.sv
`timescale 1ns/10ps

module keeper_overlay (
    input  logic                      clk,
    input  logic                      rst,
    input  shoot_pkg::pix_t           hcount,
    input  shoot_pkg::pix_t           vcount,
    input  shoot_pkg::rgb_t           rgb_in,
    input  shoot_pkg::keeper_shade_t  shade,
    input  shoot_pkg::edge_t          left_edge,
    input  shoot_pkg::edge_t          right_edge,
    output shoot_pkg::pix_t           hcount_out,
    output shoot_pkg::pix_t           vcount_out,
    output shoot_pkg::rgb_t           rgb_out
);
    import shoot_pkg::*;

    logic in_box;
    rgb_t rgb_nxt;

    assign in_box = (hcount >= left_edge) && (hcount <= right_edge) &&
                    (vcount >= GK_TOP_Y) && (vcount <= GK_BOTTOM_Y);

    always_comb begin
        rgb_nxt = rgb_in;
        if (in_box) begin
            case (shade)
                SHADE_AIM:  rgb_nxt = COLOR_AIM;
                SHADE_GOAL: rgb_nxt = COLOR_GOAL;
                SHADE_MISS: rgb_nxt = COLOR_MISS;
                default:    rgb_nxt = rgb_in;    // none, pass through
            endcase
        end
    end

    // single pipeline stage, counters stay aligned with colour
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount_out <= '0;
            vcount_out <= '0;
            rgb_out    <= '0;
        end
        else begin
            hcount_out <= hcount;
            vcount_out <= vcount;
            rgb_out    <= rgb_nxt;
        end
    end

endmodule

// File: logic/keeper_window.sv
`timescale 1ns/10ps

module keeper_window (
    input  logic                   clk,
    input  logic                   rst,
    input  shoot_pkg::game_mode_t  game_mode,
    input  shoot_pkg::edge_t       keeper_pos,
    output shoot_pkg::edge_t       left_edge,
    output shoot_pkg::edge_t       right_edge
);
    import shoot_pkg::*;

    edge_t centre;

    // remote centre held inside the screen
    always_comb begin
        if (keeper_pos < GK_CLAMP_MIN) begin
            centre = GK_CLAMP_MIN;
        end
        else if (keeper_pos > GK_CLAMP_MAX) begin
            centre = GK_CLAMP_MAX;
        end
        else begin
            centre = keeper_pos;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            left_edge  <= GK_SOLO_LEFT;
            right_edge <= GK_SOLO_LEFT + GK_WIDTH;
        end
        else if (game_mode == SOLO) begin
            left_edge  <= GK_SOLO_LEFT;                 // fixed box
            right_edge <= GK_SOLO_LEFT + GK_WIDTH;
        end
        else begin
            left_edge  <= centre - GK_HALF_WIDTH;
            right_edge <= centre + GK_HALF_WIDTH;
        end
    end

endmodule

// File: logic/shoot_pkg.sv
package shoot_pkg;

    typedef logic [11:0] rgb_t;
    typedef logic [10:0] pix_t;
    typedef logic [9:0]  edge_t;
    typedef logic [7:0]  tx_byte_t;

    typedef enum logic {
        SOLO,
        MULTI
    } game_mode_t;

    typedef enum logic [1:0] {
        SHADE_NONE,    // keeper not drawn
        SHADE_AIM,
        SHADE_GOAL,
        SHADE_MISS
    } keeper_shade_t;

    // goal mouth, inclusive bounds
    localparam pix_t SCREEN_WIDTH    = 11'd1024;
    localparam pix_t POST_INNER_EDGE = 11'd212;
    localparam pix_t CROSSBAR_BOTTOM = 11'd150;
    localparam pix_t POST_BOTTOM     = 11'd600;

    // keeper box
    localparam edge_t GK_SOLO_LEFT  = 10'd400;
    localparam edge_t GK_WIDTH      = 10'd200;
    localparam edge_t GK_HALF_WIDTH = 10'd100;
    localparam pix_t  GK_TOP_Y      = 11'd250;
    localparam pix_t  GK_BOTTOM_Y   = 11'd550;

    // remote keeper centre limits, keeps the box on screen
    localparam edge_t GK_CLAMP_MIN = 10'd255;
    localparam edge_t GK_CLAMP_MAX = 10'd769;

    // verdict must stay high RESULT_DEBOUNCE+1 cycles
    localparam int RESULT_DEBOUNCE     = 10;
    localparam int HOLD_CYCLES_DEFAULT = 16_250_000;    // 0.25 s at 65 MHz

    // receiver buffer depth
    localparam int TX_CREDITS = 4;

    // byte opcodes, low three bits
    localparam logic [2:0] OP_X_LO = 3'd3;
    localparam logic [2:0] OP_X_HI = 3'd4;
    localparam logic [2:0] OP_Y_LO = 3'd5;
    localparam logic [2:0] OP_Y_HI = 3'd6;

    localparam rgb_t COLOR_AIM  = 12'h00F;    // blue
    localparam rgb_t COLOR_GOAL = 12'h0F0;
    localparam rgb_t COLOR_MISS = 12'hF00;

endpackage
